// ==== Bender.yml ====
package:
  name: cpuh

sources:
  - cpuh_pkg.sv
  - cpu_core.sv
  - bus_serializer.sv
  - cpuh_top.sv
  - target: test
    files:
      - cpuh_properties.sv
      - tb_clock_gen.sv
      - tb_cpuh.sv

// ==== bus_serializer.sv ====
// Frame counter and byte-serial bridge from the 32-bit bus request to the 8-bit pins
`timescale 1ns/1ps
`default_nettype none

module bus_serializer import cpuh_pkg::*; (
  input  wire         clk,
  input  wire         arst_n,
  input  wire bus_req_t req,
  output logic        step,     // Pulse at PH_STEP
  output logic [31:0] rdata,    // Gathered read word
  input  wire  [7:0]  uio_in,
  output logic [7:0]  uo_out,
  output logic [7:0]  uio_out,
  output logic [7:0]  uio_oe
);

  localparam int CNT_W = $clog2(FRAME_LEN);

  logic [CNT_W-1:0] cnt_q;
  logic             primed_q;   // Blocks the step in the cycle right after reset
  frame_phase_e     phase;
  logic [7:0]       uo_d;
  logic [7:0]       uio_d;
  logic [3:0][7:0]  rbyte_q;    // Read bytes, index 0 is the low byte

  // Frame counter, 0 to FRAME_LEN-1
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q <= '0;
    end else if (cnt_q == CNT_W'(FRAME_LEN - 1)) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      primed_q <= 1'b0;
    end else begin
      primed_q <= 1'b1;
    end
  end

  assign phase = frame_phase_e'(cnt_q);
  assign step  = primed_q && (phase == PH_STEP);

  // Address bytes low first, then the direction byte
  always_comb begin
    case (phase)
      PH_ADDR0: uo_d = req.addr[7:0];
      PH_ADDR1: uo_d = req.addr[15:8];
      PH_ADDR2: uo_d = req.addr[23:16];
      PH_ADDR3: uo_d = req.addr[31:24];
      PH_DIR:   uo_d = {7'b0000000, req.write};
      default:  uo_d = 8'h00;
    endcase
  end

  // Write data bytes low first, only in write frames
  always_comb begin
    uio_d = 8'h00;
    if (req.write) begin
      case (phase)
        PH_DATA0: uio_d = req.wdata[7:0];
        PH_DATA1: uio_d = req.wdata[15:8];
        PH_DATA2: uio_d = req.wdata[23:16];
        PH_DATA3: uio_d = req.wdata[31:24];
        default:  uio_d = 8'h00;
      endcase
    end
  end

  // Pin bytes lag the counter by one cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      uo_out  <= 8'h00;
      uio_out <= 8'h00;
    end else begin
      uo_out  <= uo_d;
      uio_out <= uio_d;
    end
  end

  // The request only changes on a step, so this holds for the whole frame
  assign uio_oe = {8{req.write}};

  // Memory drives byte k during the cycle at PH_DATA0 + k
  always_ff @(posedge clk) begin
    if (!req.write) begin
      case (phase)
        PH_DATA0: rbyte_q[0] <= uio_in;
        PH_DATA1: rbyte_q[1] <= uio_in;
        PH_DATA2: rbyte_q[2] <= uio_in;
        PH_DATA3: rbyte_q[3] <= uio_in;
        default:  rbyte_q    <= rbyte_q;
      endcase
    end
  end

  assign rdata = rbyte_q;  // Complete at PH_STEP

endmodule

`default_nettype wire

// ==== compile.f ====
cpuh_pkg.sv
cpu_core.sv
bus_serializer.sv
cpuh_top.sv
cpuh_properties.sv
tb_clock_gen.sv
tb_cpuh.sv

// ==== cpu_core.sv ====
// Accumulator processor stepping once per bus frame
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpuh_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  wire         clk,
  input  wire         arst_n,
  input  wire         step,     // One pulse per frame
  input  wire  [31:0] rdata,    // Read data of the frame just ended
  input  wire  [7:0]  in_port,
  output bus_req_t    req
);

  core_state_e state_q, state_d;
  logic        run_q;            // Low until the first step
  logic [31:0] pc_q, pc_d;
  logic [31:0] acc_q, acc_d;
  logic [31:0] instr_q;          // Latched instruction word
  bus_req_t    req_d;

  opcode_e     fetch_op;
  opcode_e     exec_op;
  logic [31:0] fetch_addr;
  logic [31:0] exec_addr;

  // Build a read request with no write payload
  function automatic bus_req_t read_req(input logic [31:0] addr);
    bus_req_t r;
    r.addr  = addr;
    r.wdata = '0;
    r.write = 1'b0;
    return r;
  endfunction

  assign fetch_op   = opcode_e'(rdata[31:24]);
  assign exec_op    = opcode_e'(instr_q[31:24]);
  assign fetch_addr = {8'h00, rdata[23:0]};    // Word-aligned operand
  assign exec_addr  = {8'h00, instr_q[23:0]};

  always_comb begin
    state_d = state_q;
    pc_d    = pc_q;
    acc_d   = acc_q;
    req_d   = req;

    if (!run_q) begin
      // First step only issues the fetch at the reset address
      req_d = read_req(pc_q);
    end else begin
      case (state_q)
        FETCH: begin
          state_d = EXECUTE;
          case (fetch_op)
            OP_LOAD,
            OP_ADD: begin
              req_d = read_req(fetch_addr);  // Operand read
            end
            OP_STORE: begin
              req_d.addr  = fetch_addr;
              req_d.wdata = acc_q;
              req_d.write = 1'b1;
            end
            default: begin
              req_d = read_req(pc_q);  // No operand, idle read at pc
            end
          endcase
        end

        EXECUTE: begin
          state_d = FETCH;
          pc_d    = pc_q + 32'd4;
          case (exec_op)
            OP_LOAD:  acc_d = rdata;
            OP_ADD:   acc_d = acc_q + rdata;   // Wraps modulo 2^32
            OP_IN:    acc_d = {24'h000000, in_port};
            OP_STORE: acc_d = acc_q;           // Write went out last frame
            OP_JUMP:  pc_d  = exec_addr;
            default: begin
              // HALT and unknown opcodes keep pc so the bus address freezes
              state_d = HALTED;
              pc_d    = pc_q;
            end
          endcase
          req_d = read_req(pc_d);
        end

        default: begin
          req_d = read_req(pc_q);  // Halted, repeat the same read forever
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= FETCH;
      run_q   <= 1'b0;
      pc_q    <= RESET_PC;
      acc_q   <= '0;
      req     <= '0;        // First frame reads address zero
    end else if (step) begin
      state_q <= state_d;
      run_q   <= 1'b1;
      pc_q    <= pc_d;
      acc_q   <= acc_d;
      req     <= req_d;
    end
  end

  // Instruction latch, taken only at the end of a fetch frame
  always_ff @(posedge clk) begin
    if (step && run_q && (state_q == FETCH)) begin
      instr_q <= rdata;
    end
  end

endmodule

`default_nettype wire

// ==== cpuh_pkg.sv ====
// Shared types for the pin-serialized processor: bus request, frame phases, opcodes, core states
`default_nettype none

package cpuh_pkg;

  // Clock cycles per bus frame, fixed by the byte layout below
  localparam int unsigned FRAME_LEN = 10;

  // One bus request, held for a whole frame
  typedef struct packed {
    logic [31:0] addr;   // Byte address of one word
    logic [31:0] wdata;  // Write data word
    logic        write;  // 1 = write frame, 0 = read frame
  } bus_req_t;

  // Frame counter values
  typedef enum logic [3:0] {
    PH_STEP  = 4'd0,  // Core steps here
    PH_ADDR0 = 4'd1,
    PH_ADDR1 = 4'd2,
    PH_ADDR2 = 4'd3,
    PH_ADDR3 = 4'd4,
    PH_DIR   = 4'd5,  // Direction byte
    PH_DATA0 = 4'd6,
    PH_DATA1 = 4'd7,
    PH_DATA2 = 4'd8,
    PH_DATA3 = 4'd9
  } frame_phase_e;

  // Instruction top byte, unknown values act as HALT
  typedef enum logic [7:0] {
    OP_HALT  = 8'h00,  // Erased memory halts the core
    OP_LOAD  = 8'h01,
    OP_ADD   = 8'h02,
    OP_STORE = 8'h03,
    OP_IN    = 8'h04,
    OP_JUMP  = 8'h05
  } opcode_e;

  typedef enum logic [1:0] {
    FETCH   = 2'd0,
    EXECUTE = 2'd1,
    HALTED  = 2'd2
  } core_state_e;

endpackage

`default_nettype wire

// ==== cpuh_properties.sv ====
// Frame timing and bus content assertions bound to the serializer
`timescale 1ns/1ps
`default_nettype none

module cpuh_properties import cpuh_pkg::*; (
  input wire               clk,
  input wire               arst_n,
  input wire               step,
  input wire frame_phase_e phase,
  input wire bus_req_t     req,
  input wire  [7:0]        uo_out,
  input wire  [7:0]        uio_out,
  input wire  [7:0]        uio_oe
);

  int unsigned fail_cnt = 0;  // Read by the testbench at the end

  // The direction byte is on the pins while the counter shows PH_DATA0
  oe_dir_match: assert property (@(posedge clk) disable iff (!arst_n)
    (phase == PH_DATA0) |-> (uio_oe == {8{uo_out[0]}}))
    else begin
      $error("uio_oe disagrees with the direction byte on uo_out");
      fail_cnt++;
    end

  // Output enable may only change where one frame hands over to the next
  oe_steady: assert property (@(posedge clk) disable iff (!arst_n)
    (phase != PH_STEP) |=> $stable(uio_oe))
    else begin
      $error("uio_oe changed in the middle of a frame");
      fail_cnt++;
    end

  dir_byte: assert property (@(posedge clk) disable iff (!arst_n)
    (phase == PH_DATA0) |-> (uo_out[7:1] == 7'd0))
    else begin
      $error("direction byte on uo_out has bits set other than bit 0");
      fail_cnt++;
    end

  uio_quiet: assert property (@(posedge clk) disable iff (!arst_n)
    (uio_oe == 8'h00) |-> (uio_out == 8'h00))
    else begin
      $error("uio_out is not zero during a read frame");
      fail_cnt++;
    end

  step_period: assert property (@(posedge clk) disable iff (!arst_n)
    step |-> ##FRAME_LEN step)
    else begin
      $error("step pulse did not repeat one frame later");
      fail_cnt++;
    end

  req_held: assert property (@(posedge clk) disable iff (!arst_n)
    !step |=> $stable(req))
    else begin
      $error("bus request changed without a step");
      fail_cnt++;
    end

endmodule

bind bus_serializer cpuh_properties u_props (
  .clk     (clk),
  .arst_n  (arst_n),
  .step    (step),
  .phase   (phase),
  .req     (req),
  .uo_out  (uo_out),
  .uio_out (uio_out),
  .uio_oe  (uio_oe)
);

`default_nettype wire

// ==== cpuh_top.sv ====
// Tile top connecting the accumulator core to the pin serializer
`timescale 1ns/1ps
`default_nettype none

module cpuh_top import cpuh_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0000_0100
) (
  input  wire        clk,
  input  wire        arst_n,
  input  wire        ena,      // Tile enable, always high when powered
  input  wire  [7:0] ui_in,    // Dedicated inputs, feed the IN instruction
  output logic [7:0] uo_out,   // Address and direction bytes
  input  wire  [7:0] uio_in,   // Read data from external memory
  output logic [7:0] uio_out,  // Write data to external memory
  output logic [7:0] uio_oe    // High while the tile drives uio
);

  bus_req_t    req;
  logic        step;
  logic [31:0] rdata;

  cpu_core #(
    .RESET_PC (RESET_PC)
  ) u_core (
    .clk     (clk),
    .arst_n  (arst_n),
    .step    (step),
    .rdata   (rdata),
    .in_port (ui_in),
    .req     (req)
  );

  bus_serializer u_ser (
    .clk     (clk),
    .arst_n  (arst_n),
    .req     (req),
    .step    (step),
    .rdata   (rdata),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  // Unused tile inputs
  logic unused_ok;
  assign unused_ok = &{ena, 1'b0};

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// Testbench clock source and power-on reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;  // Released just after an edge
  end

endmodule

`default_nettype wire

// ==== tb_cpuh.sv ====
// Testbench top with the external memory model, program, frame checks, watchdog and report
`timescale 1ns/1ps
`default_nettype none

module tb_cpuh import cpuh_pkg::*; ();

  localparam logic [31:0] RESET_PC   = 32'h0000_0100;
  localparam logic [31:0] A_ADDR     = 32'h0000_0200;
  localparam logic [31:0] B_ADDR     = 32'h0000_0204;
  localparam logic [31:0] C_ADDR     = 32'h0000_0280;
  localparam logic [31:0] D_ADDR     = 32'h0000_0284;
  localparam logic [31:0] JUMP_PC    = 32'h0000_0120;
  localparam logic [31:0] HALT_PC    = 32'h0000_0128;
  localparam int          RUN_FRAMES = 20;
  localparam int          NUM_TESTS  = 5;
  localparam int          T_ADDR     = 0;
  localparam int          T_LAS      = 1;
  localparam int          T_IN       = 2;
  localparam int          T_JH       = 3;
  localparam int          T_SHAPE    = 4;
  // Run length plus reset cycles and a margin
  localparam int          WATCHDOG_NS = (RUN_FRAMES * FRAME_LEN + 3 + 50) * 10;

  logic       clk;
  logic       arst_n;
  logic       ena;
  logic [7:0] ui_in;
  logic [7:0] uio_in = 8'h00;
  logic [7:0] uo_out;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;

  logic [31:0] mem [logic [31:0]];  // Off-chip memory indexed by word byte address
  logic [31:0] exp_addr [$];
  bit          exp_write [$];
  logic [31:0] exp_wdata [$];
  bit          exp_chk [$];         // Address checked in this frame
  int          exp_test [$];
  int          errs [NUM_TESTS] = '{default: 0};
  int          frames_done = 0;
  int          pin_cnt = 0;         // Mirror of the DUT frame counter
  bit          frame_open = 1'b0;
  logic [31:0] cur_addr = '0;
  logic [31:0] cur_wdata = '0;
  bit          cur_write = 1'b0;
  integer      seed;
  logic [31:0] a_val;
  logic [31:0] b_val;
  logic [7:0]  in_val;

  tb_clock_gen u_clk (.clk(clk), .arst_n(arst_n));

  cpuh_top #(.RESET_PC(RESET_PC)) uut (
    .clk(clk), .arst_n(arst_n), .ena(ena), .ui_in(ui_in), .uo_out(uo_out),
    .uio_in(uio_in), .uio_out(uio_out), .uio_oe(uio_oe)
  );

  function automatic logic [31:0] mem_read(input logic [31:0] addr);
    if (mem.exists(addr)) return mem[addr];
    else return {addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1;  // Unwritten words
  endfunction

  function automatic logic [31:0] encode_instr(input opcode_e op, input logic [31:0] addr);
    return {op, addr[23:0]};
  endfunction

  task automatic expect_frame(input logic [31:0] addr, input bit write,
                              input logic [31:0] wdata, input bit chk, input int test);
    exp_addr.push_back(addr);
    exp_write.push_back(write);
    exp_wdata.push_back(wdata);
    exp_chk.push_back(chk);
    exp_test.push_back(test);
  endtask

  task automatic load_program();
    seed   = 32'hc5cf;
    a_val  = $random(seed);
    b_val  = $random(seed);
    in_val = $random(seed);
    mem[A_ADDR]          = a_val;
    mem[B_ADDR]          = b_val;
    mem[RESET_PC]        = encode_instr(OP_LOAD, A_ADDR);
    mem[RESET_PC + 4]    = encode_instr(OP_ADD, B_ADDR);
    mem[RESET_PC + 8]    = encode_instr(OP_STORE, C_ADDR);
    mem[RESET_PC + 12]   = encode_instr(OP_JUMP, JUMP_PC);
    mem[RESET_PC + 16]   = encode_instr(OP_HALT, 32'h0);  // Only reached if the jump fails
    mem[JUMP_PC]         = encode_instr(OP_IN, 32'h0);
    mem[JUMP_PC + 4]     = encode_instr(OP_STORE, D_ADDR);
    mem[HALT_PC]         = encode_instr(OP_HALT, 32'h0);
  endtask

  // Two frames per instruction with idle reads left unchecked
  task automatic build_expected();
    expect_frame(32'h0, 1'b0, '0, 1'b1, T_ADDR);           // Reset frame
    expect_frame(RESET_PC, 1'b0, '0, 1'b1, T_ADDR);
    expect_frame(A_ADDR, 1'b0, '0, 1'b1, T_ADDR);
    expect_frame(RESET_PC + 4, 1'b0, '0, 1'b1, T_ADDR);
    expect_frame(B_ADDR, 1'b0, '0, 1'b1, T_ADDR);
    expect_frame(RESET_PC + 8, 1'b0, '0, 1'b1, T_ADDR);
    expect_frame(C_ADDR, 1'b1, a_val + b_val, 1'b1, T_LAS);
    expect_frame(RESET_PC + 12, 1'b0, '0, 1'b1, T_ADDR);
    expect_frame(32'h0, 1'b0, '0, 1'b0, T_JH);
    expect_frame(JUMP_PC, 1'b0, '0, 1'b1, T_JH);           // Redirected fetch
    expect_frame(32'h0, 1'b0, '0, 1'b0, T_IN);
    expect_frame(JUMP_PC + 4, 1'b0, '0, 1'b1, T_ADDR);
    expect_frame(D_ADDR, 1'b1, {24'h000000, in_val}, 1'b1, T_IN);
    expect_frame(HALT_PC, 1'b0, '0, 1'b1, T_ADDR);
    while (exp_addr.size() < RUN_FRAMES) begin
      expect_frame(HALT_PC, 1'b0, '0, 1'b1, T_JH);         // Frozen after HALT
    end
  endtask

  task automatic check_frame(input int idx, input logic [31:0] addr, input bit write,
                             input logic [31:0] wdata);
    int t;
    if (idx < exp_addr.size()) begin
      t = exp_test[idx];
      if (exp_chk[idx]) begin
        assert (addr == exp_addr[idx]) else begin
          $error("error: uo_out address in frame %0d is %08h, expected %08h",
                 idx, addr, exp_addr[idx]);
          errs[t]++;
        end
      end
      assert (write == exp_write[idx]) else begin
        $error("error: uo_out direction in frame %0d is %h, expected %h",
               idx, write, exp_write[idx]);
        errs[t]++;
      end
      if (write && exp_write[idx]) begin
        assert (wdata == exp_wdata[idx]) else begin
          $error("error: uio_out data in frame %0d is %08h, expected %08h",
                 idx, wdata, exp_wdata[idx]);
          errs[t]++;
        end
      end
    end
  endtask

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) pin_cnt <= 0;
    else if (pin_cnt == FRAME_LEN - 1) pin_cnt <= 0;
    else pin_cnt <= pin_cnt + 1;
  end

  // Pins lag the counter by one cycle, so a frame closes at count 0
  always @(posedge clk) begin
    if (arst_n) begin
      if (pin_cnt == 1) frame_open = 1'b1;
      case (pin_cnt)
        2, 3, 4, 5: cur_addr[8 * (pin_cnt - 2) +: 8] = uo_out;
        6:          cur_write = uo_out[0];
        7, 8, 9:    cur_wdata[8 * (pin_cnt - 7) +: 8] = uio_out;
        default:    ;
      endcase
      if ((pin_cnt == 0) && frame_open) begin
        cur_wdata[31:24] = uio_out;
        check_frame(frames_done, cur_addr, cur_write, cur_wdata);
        if (cur_write && (uio_oe == 8'hff)) mem[cur_addr] = cur_wdata;
        frames_done++;
      end
    end
  end

  // Read byte k goes out during count 6 + k with no bus turnaround
  always @(posedge clk) begin
    logic [31:0] word;
    #1;
    word = mem_read(cur_addr);
    if (arst_n && (pin_cnt >= 6)) uio_in = word[8 * (pin_cnt - 6) +: 8];
    else uio_in = 8'h00;
  end

  task automatic wait_frames(input int n);
    wait (frames_done >= n);
  endtask

  task automatic report_test(input string name, input int t);
    if (errs[t] == 0) $display("test %s: passed", name);
    else $display("test %s: failed with %0d errors", name, errs[t]);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, %0d of %0d frames seen",
             WATCHDOG_NS, frames_done, RUN_FRAMES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    int n_pass;
    int n_err;
    ena   = 1'b1;
    ui_in = 8'h00;
    load_program();
    build_expected();
    @(posedge clk);
    #1;
    ui_in = in_val;  // Held for the whole run
    wait_frames(7);
    report_test("load_add_store", T_LAS);
    wait_frames(13);
    report_test("input_port", T_IN);
    wait_frames(RUN_FRAMES);
    report_test("addresses", T_ADDR);
    report_test("jump_halt", T_JH);
    errs[T_SHAPE] = uut.u_ser.u_props.fail_cnt;
    report_test("frame_shape", T_SHAPE);
    n_pass = 0;
    n_err  = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      if (errs[i] == 0) n_pass++;
      n_err += errs[i];
    end
    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
             NUM_TESTS, n_pass, NUM_TESTS - n_pass, n_err);
    if (n_err == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
